/* design/sad_pkg.sv */
`default_nettype none

package sad_pkg;

    localparam int REF_SAMPLES = 8;    // window length, also the number of lanes
    localparam int SAMPLE_W    = 8;
    localparam int SAD_W       = 11;   // msb doubles as the saturation flag
    localparam int IDX_W       = 3;

    typedef logic [SAMPLE_W-1:0]    sample_t;
    typedef logic [SAD_W-1:0]       sad_t;
    typedef logic [REF_SAMPLES-1:0] lane_mask_t;
    typedef logic [IDX_W-1:0]       idx_t;
    typedef logic [15:0]            trig_count_t;

    // byte-wide register map
    localparam logic [7:0] REG_STATUS            = 8'd36;
    localparam logic [7:0] REG_REF_SAMPLES       = 8'd38;
    localparam logic [7:0] REG_THRESHOLD         = 8'd40;
    localparam logic [7:0] REG_REFERENCE         = 8'd41;
    localparam logic [7:0] REG_MULTIPLE_TRIGGERS = 8'd42;
    localparam logic [7:0] REG_REFEN             = 8'd43;

    // lane i has to restart on sample i of a run; the accumulator sits three
    // edges behind adc_data, so the ring starts three lanes early at bit 5
    localparam lane_mask_t RESTART_PRESET = lane_mask_t'(1) << (REF_SAMPLES - 3);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FILLING,    // first full window not seen yet
        ST_RUNNING
    } sad_state_t;

endpackage

`default_nettype wire

/* design/sad_ifs.sv */
`timescale 1ns/100ps
`default_nettype none

// settings from the register file, status coming back from control
interface sad_cfg_if
    import sad_pkg::*;
();
    sample_t [REF_SAMPLES-1:0] reference;
    lane_mask_t                refen;
    sad_t                      threshold;
    logic                      multiple_triggers;
    logic                      clear_status;    // single cycle
    logic                      triggered;
    trig_count_t               num_triggers;

    modport regs (
        output reference, refen, threshold, multiple_triggers, clear_status,
        input  triggered, num_triggers
    );
    modport ctrl (
        input  multiple_triggers, clear_status,
        output triggered, num_triggers
    );
    modport lanes (
        input reference, refen, threshold
    );
endinterface

// window sequencing towards the lanes, hits coming back
interface sad_lane_if
    import sad_pkg::*;
();
    idx_t       position;
    lane_mask_t restart;
    lane_mask_t ready;
    lane_mask_t lane_hit;

    modport ctrl (
        output position, restart, ready,
        input  lane_hit
    );
    modport lanes (
        input  position, restart, ready,
        output lane_hit
    );
endinterface

`default_nettype wire

/* design/sad_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module sad_regs
    import sad_pkg::*;
(
    input  wire        adc_sampleclk,
    input  wire        reset,
    input  wire  [7:0] reg_address,
    input  wire  [2:0] reg_bytecnt,
    input  wire  [7:0] write_data,
    output logic [7:0] read_data,
    input  wire        reg_read,
    input  wire        reg_write,
    sad_cfg_if.regs    cfg
);

    logic status_write;

    assign status_write = reg_write && (reg_address == REG_STATUS);

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            cfg.reference         <= '0;
            cfg.refen             <= '1;    // every position compared by default
            cfg.threshold         <= '0;
            cfg.multiple_triggers <= 1'b0;
            cfg.clear_status      <= 1'b0;
        end else begin
            cfg.clear_status <= status_write;    // high the cycle after a status write
            if (reg_write) begin
                case (reg_address)
                    REG_REFERENCE: cfg.reference[reg_bytecnt] <= write_data;
                    REG_REFEN: begin
                        if (reg_bytecnt == 3'd0) begin
                            cfg.refen <= lane_mask_t'(write_data);
                        end
                    end
                    REG_THRESHOLD: begin
                        if (reg_bytecnt == 3'd0) begin
                            cfg.threshold[7:0] <= write_data;
                        end else if (reg_bytecnt == 3'd1) begin
                            cfg.threshold[SAD_W-1:8] <= write_data[SAD_W-9:0];
                        end
                    end
                    REG_MULTIPLE_TRIGGERS: cfg.multiple_triggers <= write_data[0];
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        read_data = '0;
        if (reg_read) begin
            case (reg_address)
                REG_REFERENCE: read_data = cfg.reference[reg_bytecnt];
                REG_REFEN:     read_data = (reg_bytecnt == 3'd0) ? 8'(cfg.refen) : 8'h00;
                REG_THRESHOLD: begin
                    if (reg_bytecnt == 3'd0) begin
                        read_data = cfg.threshold[7:0];
                    end else if (reg_bytecnt == 3'd1) begin
                        read_data = 8'(cfg.threshold[SAD_W-1:8]);   // upper bits read 0
                    end
                end
                REG_STATUS: begin
                    case (reg_bytecnt)
                        3'd0:    read_data = {7'b0, cfg.triggered};
                        3'd1:    read_data = cfg.num_triggers[7:0];
                        3'd2:    read_data = cfg.num_triggers[15:8];
                        default: read_data = '0;
                    endcase
                end
                REG_MULTIPLE_TRIGGERS: read_data = {7'b0, cfg.multiple_triggers};
                REG_REF_SAMPLES: read_data = (reg_bytecnt == 3'd0) ? 8'(REF_SAMPLES) : 8'h00;
                default: read_data = '0;
            endcase
        end
    end

    a_clear_single: assert property (@(posedge adc_sampleclk) disable iff (reset)
        cfg.clear_status |=> !cfg.clear_status);

endmodule

`default_nettype wire

/* design/sad_control.sv */
`timescale 1ns/100ps
`default_nettype none

module sad_control
    import sad_pkg::*;
(
    input  wire       adc_sampleclk,
    input  wire       reset,
    input  wire       armed_and_ready,
    input  wire       active,
    output logic      trigger,
    sad_cfg_if.ctrl   cfg,
    sad_lane_if.ctrl  lane
);

    sad_state_t state;
    lane_mask_t ready_q;       // lane i qualified once its first full window is in
    logic       running;
    logic       window_full;
    logic       arm_q;
    logic       arm_rise;
    logic       blocked;

    assign running     = armed_and_ready && active;
    assign window_full = (state == ST_FILLING) && (lane.position == IDX_W'(REF_SAMPLES - 1));
    assign arm_rise    = armed_and_ready && !arm_q;
    // single mode holds off after the first trigger, including the very next cycle
    assign blocked     = !cfg.multiple_triggers && (cfg.triggered || trigger);

    // a stop drops every pending hit right away
    assign lane.ready = running ? ready_q : '0;

    always_ff @(posedge adc_sampleclk) begin
        if (reset || !running) begin
            state         <= ST_IDLE;
            lane.position <= '0;
            lane.restart  <= RESTART_PRESET;
            ready_q       <= '0;
        end else begin
            lane.restart <= {lane.restart[REF_SAMPLES-2:0], lane.restart[REF_SAMPLES-1]};
            ready_q      <= {ready_q[REF_SAMPLES-2:0], window_full || (state == ST_RUNNING)};
            if (lane.position == IDX_W'(REF_SAMPLES - 1)) begin
                lane.position <= '0;
            end else begin
                lane.position <= lane.position + 1'b1;
            end
            case (state)
                ST_IDLE: state <= ST_FILLING;
                ST_FILLING: begin
                    if (window_full) begin
                        state <= ST_RUNNING;
                    end
                end
                default: state <= ST_RUNNING;
            endcase
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset || !running) begin
            trigger <= 1'b0;
        end else begin
            trigger <= (|lane.lane_hit) && !blocked;    // any lane may fire
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            arm_q <= 1'b0;
        end else begin
            arm_q <= armed_and_ready;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset || cfg.clear_status || arm_rise) begin
            cfg.triggered    <= 1'b0;
            cfg.num_triggers <= '0;
        end else if (trigger) begin
            cfg.triggered    <= 1'b1;
            cfg.num_triggers <= cfg.num_triggers + 1'b1;
        end
    end

    a_restart_onehot: assert property (@(posedge adc_sampleclk) disable iff (reset)
        $onehot(lane.restart));

    // low active keeps the trigger off for a full window plus the pipeline
    a_no_trigger_inactive: assert property (@(posedge adc_sampleclk) disable iff (reset)
        !active |=> !trigger [*REF_SAMPLES + 5]);

endmodule

`default_nettype wire

/* design/sad_lanes.sv */
`timescale 1ns/100ps
`default_nettype none

module sad_lanes
    import sad_pkg::*;
(
    input  wire          adc_sampleclk,
    input  wire sample_t adc_data,
    sad_cfg_if.lanes     cfg,
    sad_lane_if.lanes    lane
);

    sample_t    adc_r;                       // stage 1
    sample_t    adc_rr;                      // copy for the subtract stage
    sample_t    ref_chain [REF_SAMPLES];
    sample_t    ref_r     [REF_SAMPLES];
    lane_mask_t en_chain;
    lane_mask_t en_r;
    lane_mask_t dir;                         // set when the sample is above the reference
    sad_t       incr      [REF_SAMPLES];
    sad_t       acc       [REF_SAMPLES];

    // reference for the current position enters lane 0, then walks up one lane per cycle
    always_ff @(posedge adc_sampleclk) begin
        adc_r        <= adc_data;
        adc_rr       <= adc_r;
        ref_chain[0] <= cfg.reference[lane.position];
        en_chain[0]  <= cfg.refen[lane.position];
        for (int i = 1; i < REF_SAMPLES; i++) begin
            ref_chain[i] <= ref_chain[i-1];
            en_chain[i]  <= en_chain[i-1];
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        for (int i = 0; i < REF_SAMPLES; i++) begin
            dir[i]   <= adc_r > ref_chain[i];     // stage 2
            ref_r[i] <= ref_chain[i];
            en_r[i]  <= en_chain[i];

            // stage 3, masked positions add nothing
            if (!en_r[i]) begin
                incr[i] <= '0;
            end else if (dir[i]) begin
                incr[i] <= SAD_W'(adc_rr - ref_r[i]);
            end else begin
                incr[i] <= SAD_W'(ref_r[i] - adc_rr);
            end

            // stage 4
            if (lane.restart[i]) begin
                acc[i] <= incr[i];                // first sample of the next window
            end else if (!acc[i][SAD_W-1]) begin
                acc[i] <= acc[i] + incr[i];       // frozen once saturated
            end

            // stage 5 looks at the window that just completed
            lane.lane_hit[i] <= (acc[i] <= cfg.threshold) && lane.restart[i]
                                && lane.ready[i];
        end
    end

    for (genvar g = 0; g < REF_SAMPLES; g++) begin : g_acc_check
        a_acc_monotonic: assert property (@(posedge adc_sampleclk)
            !$isunknown({$past(lane.restart[g]), $past(acc[g])}) && !$past(lane.restart[g])
            |-> acc[g] >= $past(acc[g]));
    end

endmodule

`default_nettype wire

/* design/sad_top.sv */
`timescale 1ns/100ps
`default_nettype none

module sad_top
    import sad_pkg::*;
(
    input  wire          adc_sampleclk,
    input  wire          reset,
    input  wire sample_t adc_data,
    input  wire          armed_and_ready,
    input  wire          active,
    input  wire  [7:0]   reg_address,
    input  wire  [2:0]   reg_bytecnt,
    input  wire  [7:0]   write_data,
    output logic [7:0]   read_data,
    input  wire          reg_read,
    input  wire          reg_write,
    output logic         trigger
);

    sad_cfg_if  cfg_if ();
    sad_lane_if lane_if ();

    sad_regs u_regs (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .reg_address   (reg_address),
        .reg_bytecnt   (reg_bytecnt),
        .write_data    (write_data),
        .read_data     (read_data),
        .reg_read      (reg_read),
        .reg_write     (reg_write),
        .cfg           (cfg_if)
    );

    sad_control u_control (
        .adc_sampleclk   (adc_sampleclk),
        .reset           (reset),
        .armed_and_ready (armed_and_ready),
        .active          (active),
        .trigger         (trigger),
        .cfg             (cfg_if),
        .lane            (lane_if)
    );

    sad_lanes u_lanes (
        .adc_sampleclk (adc_sampleclk),
        .adc_data      (adc_data),
        .cfg           (cfg_if),
        .lane          (lane_if)
    );

endmodule

`default_nettype wire

/* test/sad_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module sad_checker
    import sad_pkg::*;
(
    input wire          adc_sampleclk,
    input wire          reset,
    input wire sample_t adc_data,
    input wire          armed_and_ready,
    input wire          active,
    input wire  [7:0]   reg_address,
    input wire  [2:0]   reg_bytecnt,
    input wire  [7:0]   write_data,
    input wire  [7:0]   read_data,
    input wire          reg_read,
    input wire          reg_write,
    input wire          trigger
);

    // window ends 6 edges back, running needed from its first sample to the trigger register
    localparam int HIST = 14;

    string       test_name = "reset";
    int          error_count = 0;
    int          trigger_total = 0;
    sample_t     ref_m [REF_SAMPLES];
    lane_mask_t  refen_m;
    sad_t        thr_m;
    logic        multi_m;
    logic        fired;
    trig_count_t count_m;
    logic        arm_q;
    sample_t     hist [HIST];        // 0 is the current edge
    logic        run_hist [HIST];

    function automatic int window_sad();
        int sum;
        int d;
        sum = 0;
        for (int j = 0; j < REF_SAMPLES; j++) begin
            d = int'(hist[HIST-1-j]) - int'(ref_m[j]);
            if (refen_m[j]) sum += (d < 0) ? -d : d;
        end
        return sum;
    endfunction

    function automatic logic window_eligible();
        for (int i = 1; i < HIST; i++) begin
            if (!run_hist[i]) return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic logic [7:0] expected_read(input logic [7:0] addr, input logic [2:0] bc);
        case (addr)
            REG_REFERENCE:         return ref_m[bc];
            REG_REFEN:             return (bc == 3'd0) ? 8'(refen_m) : 8'h00;
            REG_THRESHOLD:         return (bc == 3'd0) ? thr_m[7:0]
                                        : (bc == 3'd1) ? {5'b0, thr_m[10:8]} : 8'h00;
            REG_STATUS:            return (bc == 3'd0) ? {7'b0, fired}
                                        : (bc == 3'd1) ? count_m[7:0]
                                        : (bc == 3'd2) ? count_m[15:8] : 8'h00;
            REG_MULTIPLE_TRIGGERS: return {7'b0, multi_m};
            REG_REF_SAMPLES:       return (bc == 3'd0) ? 8'd8 : 8'h00;
            default:               return 8'h00;
        endcase
    endfunction

    always @(posedge adc_sampleclk) begin : watch
        logic       exp_trig;
        logic [7:0] exp_rd;
        if (reset) begin
            for (int i = 0; i < HIST; i++) begin
                hist[i] = '0;
                run_hist[i] = 1'b0;
            end
            for (int j = 0; j < REF_SAMPLES; j++) ref_m[j] = '0;
            refen_m = '1;
            thr_m = '0;
            multi_m = 1'b0;
            fired = 1'b0;
            count_m = '0;
            arm_q = 1'b0;
        end else begin
            for (int i = HIST - 1; i > 0; i--) begin
                hist[i] = hist[i-1];
                run_hist[i] = run_hist[i-1];
            end
            hist[0] = adc_data;
            run_hist[0] = armed_and_ready && active;

            exp_trig = window_eligible() && (window_sad() <= int'(thr_m)) && (multi_m || !fired);
            if (trigger !== exp_trig) begin
                $display("ERROR %s: trigger expected %0b actual %0b at %0t",
                         test_name, exp_trig, trigger, $time);
                error_count++;
            end
            if (exp_trig) begin
                fired = 1'b1;
                count_m++;
                trigger_total++;
            end

            exp_rd = reg_read ? expected_read(reg_address, reg_bytecnt) : 8'h00;
            if (read_data !== exp_rd) begin
                $display("ERROR %s: read addr %0d byte %0d expected %02h actual %02h",
                         test_name, reg_address, reg_bytecnt, exp_rd, read_data);
                error_count++;
            end

            if (armed_and_ready && !arm_q) begin
                fired = 1'b0;
                count_m = '0;
            end
            arm_q = armed_and_ready;

            if (reg_write) begin    // mirror of the register file
                case (reg_address)
                    REG_REFERENCE: ref_m[reg_bytecnt] = write_data;
                    REG_REFEN:     if (reg_bytecnt == 3'd0) refen_m = write_data;
                    REG_THRESHOLD: begin
                        if (reg_bytecnt == 3'd0) thr_m[7:0] = write_data;
                        else if (reg_bytecnt == 3'd1) thr_m[10:8] = write_data[2:0];
                    end
                    REG_MULTIPLE_TRIGGERS: multi_m = write_data[0];
                    REG_STATUS: begin
                        fired = 1'b0;
                        count_m = '0;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* test/tb_sad_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_sad_top
    import sad_pkg::*;
();

    localparam int CLK_PERIOD    = 100;
    localparam int REG_CYCLES    = 150;
    localparam int SETUP_CYCLES  = 80;     // config writes, arming, quiet time, status reads
    localparam int SINGLE_CYCLES = 400;
    localparam int MULTI_CYCLES  = 800;
    localparam int MASK_CYCLES   = 600;
    localparam int GATE_CYCLES   = 600;
    localparam int TOTAL_CYCLES  = REG_CYCLES + 4 * SETUP_CYCLES + SINGLE_CYCLES
                                   + MULTI_CYCLES + MASK_CYCLES + GATE_CYCLES;

    logic       adc_sampleclk;
    logic       reset;
    sample_t    adc_data;
    logic       armed_and_ready;
    logic       active;
    logic [7:0] reg_address;
    logic [2:0] reg_bytecnt;
    logic [7:0] write_data;
    logic [7:0] read_data;
    logic       reg_read;
    logic       reg_write;
    logic       trigger;

    sample_t    ref_vals [REF_SAMPLES];    // what the stimulus injects
    lane_mask_t refen_val;
    int         errors_before;
    int         triggers_before;
    int         extra_errors;
    int         tests_run;
    int         tests_failed;

    sad_top u_sad_top (.*);

    sad_checker u_checker (.*);

    initial begin
        adc_sampleclk = 1'b0;
        forever #(CLK_PERIOD / 2) adc_sampleclk = ~adc_sampleclk;
    end

    initial begin
        #((TOTAL_CYCLES + 200) * CLK_PERIOD);
        $display("run timed out after %0d cycles without finishing", TOTAL_CYCLES + 200);
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic write_reg(input logic [7:0] addr, input logic [2:0] bc, input logic [7:0] d);
        @(posedge adc_sampleclk);
        reg_address <= addr;
        reg_bytecnt <= bc;
        write_data  <= d;
        reg_write   <= 1'b1;
        @(posedge adc_sampleclk);
        reg_write   <= 1'b0;
    endtask

    // checker compares read_data while reg_read is high
    task automatic read_reg(input logic [7:0] addr, input logic [2:0] bc);
        @(posedge adc_sampleclk);
        reg_address <= addr;
        reg_bytecnt <= bc;
        reg_read    <= 1'b1;
        @(posedge adc_sampleclk);
        reg_read    <= 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge adc_sampleclk);
    endtask

    task automatic check_status();
        idle(3);    // clear pulse and counter update settle first
        for (int b = 0; b < 3; b++) begin
            read_reg(REG_STATUS, 3'(b));
        end
    endtask

    task automatic configure(input lane_mask_t mask, input logic multi, input bit flat);
        sad_t thr;
        thr = sad_t'($urandom_range(12, 40));
        for (int j = 0; j < REF_SAMPLES; j++) begin
            // flat reference so neighbouring windows match as well
            ref_vals[j] = (flat && j > 0) ? ref_vals[0] : sample_t'($urandom);
            write_reg(REG_REFERENCE, 3'(j), ref_vals[j]);
        end
        refen_val = mask;
        write_reg(REG_REFEN, 3'd0, mask);
        write_reg(REG_THRESHOLD, 3'd0, thr[7:0]);
        write_reg(REG_THRESHOLD, 3'd1, 8'(thr[SAD_W-1:8]));
        write_reg(REG_MULTIPLE_TRIGGERS, 3'd0, {7'b0, multi});
        write_reg(REG_STATUS, 3'd0, 8'h00);
        check_status();
    endtask

    task automatic start_run();
        @(posedge adc_sampleclk);
        armed_and_ready <= 1'b1;
        active          <= 1'b1;
    endtask

    task automatic stop_run();
        @(posedge adc_sampleclk);
        armed_and_ready <= 1'b0;
        active          <= 1'b0;
        idle(16);    // let the pipeline drain
    endtask

    // random samples with noisy copies of the reference mixed in
    task automatic run_stream(input int cycles, input bit gate);
        sample_t pend[$];
        int      gap;
        int      v;
        bit      drop_arm;
        gap = 0;
        drop_arm = 1'b0;
        for (int c = 0; c < cycles; c++) begin
            if (pend.size() == 0 && $urandom_range(0, 3) == 0) begin
                for (int j = 0; j < REF_SAMPLES; j++) begin
                    v = int'(ref_vals[j]) + int'($urandom_range(0, 6)) - 3;
                    if (!refen_val[j]) v = $urandom_range(0, 255);    // don't care position
                    if (v < 0) v = 0;
                    if (v > 255) v = 255;
                    pend.push_back(sample_t'(v));
                end
            end
            if (gate && gap == 0 && $urandom_range(0, 49) == 0) begin
                gap = $urandom_range(1, 4);
                drop_arm = $urandom_range(0, 1);
            end
            @(posedge adc_sampleclk);
            adc_data <= (pend.size() != 0) ? pend.pop_front() : sample_t'($urandom);
            if (gap > 0) begin
                armed_and_ready <= !drop_arm;
                active          <= drop_arm;
                gap--;
            end else begin
                armed_and_ready <= 1'b1;
                active          <= 1'b1;
            end
        end
    endtask

    task automatic begin_test(input string name);
        u_checker.test_name = name;
        errors_before = u_checker.error_count + extra_errors;
        triggers_before = u_checker.trigger_total;
    endtask

    task automatic end_test(input string name, input bit need_trigger);
        int errs;
        if (need_trigger && u_checker.trigger_total == triggers_before) begin
            $display("test %s never reached a matching window", name);
            extra_errors++;
        end
        errs = u_checker.error_count + extra_errors - errors_before;
        tests_run++;
        if (errs != 0) tests_failed++;
        $display("%s %s, %0d errors", (errs == 0) ? "PASS" : "FAIL", name, errs);
    endtask

    initial begin
        void'($urandom(32'h0282d30d));
        reset = 1'b1;
        adc_data = '0;
        armed_and_ready = 1'b0;
        active = 1'b0;
        reg_address = '0;
        reg_bytecnt = '0;
        write_data = '0;
        reg_read = 1'b0;
        reg_write = 1'b0;
        extra_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        refen_val = '1;
        idle(4);
        reset <= 1'b0;
        idle(2);

        begin_test("register_access");
        configure(lane_mask_t'($urandom), 1'b1, 1'b0);
        for (int j = 0; j < REF_SAMPLES; j++) read_reg(REG_REFERENCE, 3'(j));
        read_reg(REG_REFEN, 3'd0);
        read_reg(REG_THRESHOLD, 3'd0);
        read_reg(REG_THRESHOLD, 3'd1);
        read_reg(REG_MULTIPLE_TRIGGERS, 3'd0);
        read_reg(REG_REF_SAMPLES, 3'd0);
        idle(4);    // read_data must stay zero here
        end_test("register_access", 1'b0);

        begin_test("single_trigger");
        configure('1, 1'b0, 1'b0);
        start_run();
        run_stream(SINGLE_CYCLES, 1'b0);
        stop_run();
        check_status();
        end_test("single_trigger", 1'b1);

        begin_test("multiple_triggers");
        configure('1, 1'b1, 1'b1);
        start_run();
        run_stream(MULTI_CYCLES, 1'b0);
        stop_run();
        check_status();
        end_test("multiple_triggers", 1'b1);

        begin_test("enable_mask");
        configure(lane_mask_t'($urandom_range(1, 254)), 1'b1, 1'b0);
        start_run();
        run_stream(MASK_CYCLES, 1'b0);
        stop_run();
        check_status();
        end_test("enable_mask", 1'b1);

        begin_test("gating_and_clear");
        configure('1, 1'b1, 1'b0);
        start_run();
        run_stream(GATE_CYCLES / 2, 1'b1);
        stop_run();
        check_status();
        write_reg(REG_STATUS, 3'd0, 8'h5a);
        check_status();
        start_run();    // re-arm also clears
        run_stream(GATE_CYCLES / 2, 1'b1);
        stop_run();
        check_status();
        end_test("gating_and_clear", 1'b1);

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed,
                 u_checker.error_count + extra_errors);
        if (tests_failed == 0 && u_checker.error_count + extra_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
design/sad_pkg.sv
design/sad_ifs.sv
design/sad_regs.sv
design/sad_control.sv
design/sad_lanes.sv
design/sad_top.sv
test/sad_checker.sv
test/tb_sad_top.sv

/* Bender.yml */
package:
  name: sad_trigger

sources:
  - design/sad_pkg.sv
  - design/sad_ifs.sv
  - design/sad_regs.sv
  - design/sad_control.sv
  - design/sad_lanes.sv
  - design/sad_top.sv
  - target: simulation
    files:
      - test/sad_checker.sv
      - test/tb_sad_top.sv
